// File: Makefile
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module dbg_mem_top -f all.f

sim:
	verilator --binary --timing --top-module tb_dbg_mem --Mdir obj_dir -f all.f
	./obj_dir/Vtb_dbg_mem | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: all.f
+incdir+.
dbg_map_pkg.sv
dbg_bus_pkg.sv
dbg_req_decode.sv
dbg_state_regs.sv
dbg_rsp_mux.sv
dbg_mem_top.sv
tb_dbg_mem.sv

// File: dbg_bus_pkg.sv
package dbg_bus_pkg;
  import dbg_map_pkg::*;

  // ------------------------------
  // bus side request
  // ------------------------------

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } bus_req_t;

  // one decoded access with its write strobes
  typedef struct packed {
    logic        rd;
    dbg_region_e region;
    logic [3:0]  index;
    logic        wr_halted;
    logic        wr_going;
    logic        wr_resuming;
    logic        wr_exception;
    logic        wr_data;
    logic [31:0] wdata;
    logic [3:0]  be;
  } dbg_access_t;

  // hart flags and command control
  typedef struct packed {
    logic halted;
    logic resuming;
    logic busy;
    logic go;
    logic resume;
  } hart_status_t;

  // ------------------------------
  // instruction words
  // ------------------------------

  localparam logic [6:0] OPC_JAL = 7'h6f;

  // J-type layout, immediate bits scattered as in the isa
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } jal_t;

  typedef union packed {
    logic [31:0] raw;
    jal_t        jal;
  } instr_word_u;

endpackage

// File: dbg_map_pkg.sv
package dbg_map_pkg;

  // ------------------------------
  // debug memory map
  // ------------------------------

  // only the low address bits take part in decoding
  localparam int unsigned DBG_ADDR_BITS = 12;

  // hart status flag write addresses
  localparam logic [DBG_ADDR_BITS-1:0] HALTED_ADDR    = 12'h100;
  localparam logic [DBG_ADDR_BITS-1:0] GOING_ADDR     = 12'h108;
  localparam logic [DBG_ADDR_BITS-1:0] RESUMING_ADDR  = 12'h110;
  localparam logic [DBG_ADDR_BITS-1:0] EXCEPTION_ADDR = 12'h118;

  // jump slot and data window
  localparam logic [DBG_ADDR_BITS-1:0] WHERETO_ADDR   = 12'h300;
  localparam logic [DBG_ADDR_BITS-1:0] DATA_BASE_ADDR = 12'h380;

  // per-hart flag bytes
  localparam logic [DBG_ADDR_BITS-1:0] FLAGS_BASE_ADDR = 12'h400;
  localparam logic [DBG_ADDR_BITS-1:0] FLAGS_END_ADDR  = 12'h7FF;

  // resume entry inside the rom range
  localparam logic [DBG_ADDR_BITS-1:0] RESUME_ADDR = 12'h808;

  // jal immediate from the whereto slot to the resume entry
  localparam logic [20:0] RESUME_JUMP_OFS = 21'(RESUME_ADDR - WHERETO_ADDR);

  // program buffer sits right below the data words
  function automatic logic [DBG_ADDR_BITS-1:0] progbuf_base(input int unsigned pb_size);
    return DATA_BASE_ADDR - DBG_ADDR_BITS'(4 * pb_size);
  endfunction

  // jal immediate from the whereto slot to the program buffer
  function automatic logic [20:0] progbuf_jump_ofs(input int unsigned pb_size);
    return 21'(progbuf_base(pb_size) - WHERETO_ADDR);
  endfunction

  // region that a bus access falls into
  typedef enum logic [2:0] {
    REG_NONE,
    REG_DATA,
    REG_PROGBUF,
    REG_WHERETO,
    REG_FLAGS
  } dbg_region_e;

endpackage

// File: dbg_mem_top.sv
`timescale 1ns/10ps

module dbg_mem_top
  import dbg_bus_pkg::*;
#(
  parameter int unsigned PROG_BUF_SIZE = 8,
  parameter int unsigned DATA_COUNT    = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // core side bus
  input  bus_req_t                       bus_req_i,
  output logic [31:0]                    rdata_o,
  // debugger side
  input  logic                           haltreq_i,
  input  logic                           resumereq_i,
  input  logic                           cmd_valid_i,
  input  logic                           clear_resumeack_i,
  input  logic                           ndmreset_i,
  input  logic                           data_load_i,
  input  logic [DATA_COUNT-1:0][31:0]    data_i,
  input  logic [PROG_BUF_SIZE-1:0][31:0] progbuf_i,
  output logic                           debug_req_o,
  output logic                           halted_o,
  output logic                           resuming_o,
  output logic                           cmdbusy_o,
  output logic                           cmd_exception_o,
  output logic [DATA_COUNT-1:0][31:0]    data_o,
  output logic                           data_valid_o
);

  dbg_access_t access;
  hart_status_t status;

  // halt request goes straight through to the core
  assign debug_req_o = haltreq_i;
  assign halted_o    = status.halted;
  assign resuming_o  = status.resuming;
  assign cmdbusy_o   = status.busy;

  // ------------------------------
  // decode, state, response
  // ------------------------------
  dbg_req_decode #(
    .PROG_BUF_SIZE(PROG_BUF_SIZE),
    .DATA_COUNT   (DATA_COUNT)
  ) u_decode (
    .bus_req_i(bus_req_i),
    .access_o (access)
  );

  dbg_state_regs #(
    .DATA_COUNT(DATA_COUNT)
  ) u_state (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .access_i         (access),
    .resumereq_i      (resumereq_i),
    .cmd_valid_i      (cmd_valid_i),
    .clear_resumeack_i(clear_resumeack_i),
    .ndmreset_i       (ndmreset_i),
    .data_load_i      (data_load_i),
    .data_i           (data_i),
    .status_o         (status),
    .data_o           (data_o),
    .data_valid_o     (data_valid_o),
    .cmd_exception_o  (cmd_exception_o)
  );

  // read path sees the registered data words
  dbg_rsp_mux #(
    .PROG_BUF_SIZE(PROG_BUF_SIZE),
    .DATA_COUNT   (DATA_COUNT)
  ) u_rsp (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .access_i (access),
    .status_i (status),
    .data_i   (data_o),
    .progbuf_i(progbuf_i),
    .rdata_o  (rdata_o)
  );

endmodule

// File: dbg_req_decode.sv
`timescale 1ns/10ps

module dbg_req_decode
  import dbg_map_pkg::*;
  import dbg_bus_pkg::*;
#(
  parameter int unsigned PROG_BUF_SIZE = 8,
  parameter int unsigned DATA_COUNT    = 2
) (
  input  bus_req_t    bus_req_i,
  output dbg_access_t access_o
);

  localparam logic [DBG_ADDR_BITS-1:0] PB_BASE  = progbuf_base(PROG_BUF_SIZE);
  // last byte of the data window
  localparam logic [DBG_ADDR_BITS-1:0] DATA_END =
    DATA_BASE_ADDR + DBG_ADDR_BITS'(4 * DATA_COUNT - 1);

  logic [DBG_ADDR_BITS-1:0] addr;
  logic [DBG_ADDR_BITS-1:0] ofs;
  dbg_region_e              region;
  logic                     is_wr;

  assign addr  = bus_req_i.addr[DBG_ADDR_BITS-1:0];
  assign is_wr = bus_req_i.req & bus_req_i.we;

  // ------------------------------
  // region and offset
  // ------------------------------
  always_comb begin
    region = REG_NONE;
    ofs    = '0;
    if (addr >= DATA_BASE_ADDR && addr <= DATA_END) begin
      region = REG_DATA;
      ofs    = addr - DATA_BASE_ADDR;
    end else if (addr >= PB_BASE && addr < DATA_BASE_ADDR) begin
      region = REG_PROGBUF;
      ofs    = addr - PB_BASE;
    end else if (addr == WHERETO_ADDR) begin
      region = REG_WHERETO;
    end else if (addr >= FLAGS_BASE_ADDR && addr <= FLAGS_END_ADDR) begin
      region = REG_FLAGS;
      ofs    = addr - FLAGS_BASE_ADDR;
    end
  end

  // ------------------------------
  // access word
  // ------------------------------
  always_comb begin
    access_o.rd     = bus_req_i.req & ~bus_req_i.we;
    access_o.region = region;
    // far flag bytes saturate so they never alias word 0
    access_o.index  = (ofs[DBG_ADDR_BITS-1:6] == '0) ? ofs[5:2] : '1;
    // at most one of these fires per write
    access_o.wr_halted    = is_wr && (addr == HALTED_ADDR);
    access_o.wr_going     = is_wr && (addr == GOING_ADDR);
    access_o.wr_resuming  = is_wr && (addr == RESUMING_ADDR);
    access_o.wr_exception = is_wr && (addr == EXCEPTION_ADDR);
    access_o.wr_data      = is_wr && (region == REG_DATA);
    access_o.wdata        = bus_req_i.wdata;
    access_o.be           = bus_req_i.be;
  end

endmodule

// File: dbg_rsp_mux.sv
`timescale 1ns/10ps

module dbg_rsp_mux
  import dbg_map_pkg::*;
  import dbg_bus_pkg::*;
#(
  parameter int unsigned PROG_BUF_SIZE = 8,
  parameter int unsigned DATA_COUNT    = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  dbg_access_t                    access_i,
  input  hart_status_t                   status_i,
  input  logic [DATA_COUNT-1:0][31:0]    data_i,
  input  logic [PROG_BUF_SIZE-1:0][31:0] progbuf_i,
  output logic [31:0]                    rdata_o
);

  localparam logic [20:0] PB_JUMP_OFS = progbuf_jump_ofs(PROG_BUF_SIZE);

  instr_word_u jump;
  logic [20:0] jump_ofs;
  logic        jump_en;
  logic [31:0] rdata_d;

  // ------------------------------
  // whereto jump
  // ------------------------------
  always_comb begin
    jump_en  = 1'b1;
    jump_ofs = '0;
    // a pending command beats a pending resume
    if (status_i.busy) begin
      jump_ofs = PB_JUMP_OFS;
    end else if (status_i.resume) begin
      jump_ofs = RESUME_JUMP_OFS;
    end else begin
      jump_en = 1'b0;
    end
    // jal x0 with the scattered immediate
    jump.jal.imm20    = jump_ofs[20];
    jump.jal.imm10_1  = jump_ofs[10:1];
    jump.jal.imm11    = jump_ofs[11];
    jump.jal.imm19_12 = jump_ofs[19:12];
    jump.jal.rd       = 5'd0;
    jump.jal.opcode   = OPC_JAL;
  end

  // ------------------------------
  // read word select
  // ------------------------------
  always_comb begin
    rdata_d = '0;
    unique case (access_i.region)
      REG_DATA: begin
        for (int i = 0; i < DATA_COUNT; i++) begin
          if (access_i.index == 4'(i)) rdata_d = data_i[i];
        end
      end
      REG_PROGBUF: begin
        for (int i = 0; i < PROG_BUF_SIZE; i++) begin
          if (access_i.index == 4'(i)) rdata_d = progbuf_i[i];
        end
      end
      REG_WHERETO: if (jump_en) rdata_d = jump.raw;
      // only hart 0 owns a flag byte
      REG_FLAGS: if (access_i.index == '0) rdata_d[1:0] = {status_i.resume, status_i.go};
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (access_i.rd) begin
      rdata_o <= rdata_d;
    end
  end

endmodule

// File: dbg_state_regs.sv
`timescale 1ns/10ps

module dbg_state_regs
  import dbg_bus_pkg::*;
#(
  parameter int unsigned DATA_COUNT = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  dbg_access_t                 access_i,
  input  logic                        resumereq_i,
  input  logic                        cmd_valid_i,
  input  logic                        clear_resumeack_i,
  input  logic                        ndmreset_i,
  input  logic                        data_load_i,
  input  logic [DATA_COUNT-1:0][31:0] data_i,
  output hart_status_t                status_o,
  output logic [DATA_COUNT-1:0][31:0] data_o,
  output logic                        data_valid_o,
  output logic                        cmd_exception_o
);

  hart_status_t                status_d, status_q;
  logic [DATA_COUNT-1:0][31:0] data_d, data_q;
  logic                        idle_halted;

  // commands and resume only accepted from a parked hart
  assign idle_halted = status_q.halted & ~status_q.busy;

  // ------------------------------
  // hart flags and command control
  // ------------------------------
  always_comb begin
    status_d = status_q;
    // debugger requests first so core writes below take priority
    if (cmd_valid_i && idle_halted) begin
      status_d.busy = 1'b1;
      status_d.go   = 1'b1;
    end
    if (resumereq_i && idle_halted) begin
      status_d.resume = 1'b1;
    end
    if (access_i.wr_halted) begin
      status_d.halted = 1'b1;
      // core is back in the park loop after running the program buffer
      if (status_q.busy && !status_q.go) begin
        status_d.busy = 1'b0;
      end
    end
    // core picked up the go flag
    if (access_i.wr_going) begin
      status_d.go = 1'b0;
    end
    if (access_i.wr_resuming) begin
      status_d.halted   = 1'b0;
      status_d.resume   = 1'b0;
      status_d.resuming = 1'b1;
    end
    // exception aborts the running command
    if (access_i.wr_exception) begin
      status_d.busy = 1'b0;
      status_d.go   = 1'b0;
    end
    if (clear_resumeack_i) begin
      status_d.resuming = 1'b0;
    end
    if (ndmreset_i) begin
      status_d.halted   = 1'b0;
      status_d.resuming = 1'b0;
      status_d.resume   = 1'b0;
    end
  end

  // ------------------------------
  // data words
  // ------------------------------
  always_comb begin
    data_d = data_q;
    if (data_load_i) begin
      data_d = data_i;
    end
    // core byte writes land on top of a same-cycle load
    for (int i = 0; i < DATA_COUNT; i++) begin
      for (int b = 0; b < 4; b++) begin
        if (access_i.wr_data && access_i.index == 4'(i) && access_i.be[b]) begin
          data_d[i][b*8 +: 8] = access_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q        <= '0;
      data_q          <= '0;
      data_valid_o    <= 1'b0;
      cmd_exception_o <= 1'b0;
    end else begin
      status_q        <= status_d;
      data_q          <= data_d;
      // single-cycle pulses trailing the core write
      data_valid_o    <= access_i.wr_data;
      cmd_exception_o <= access_i.wr_exception;
    end
  end

  assign status_o = status_q;
  assign data_o   = data_q;

endmodule

// File: tb_dbg_mem_tasks.svh
// ------------------------------
// bus and debugger drive
// ------------------------------

// one write that returns on the falling edge where its effect shows
task automatic bus_write(input logic [DBG_ADDR_BITS-1:0] addr, input logic [31:0] wdata,
                         input logic [3:0] be);
  @(negedge clk);
  bus_req.req   = 1'b1;
  bus_req.we    = 1'b1;
  bus_req.addr  = 32'(addr);
  bus_req.wdata = wdata;
  bus_req.be    = be;
  @(negedge clk);
  bus_req = '0;
endtask

// read request for this falling edge with rdata one edge later
task automatic bus_read_issue(input logic [DBG_ADDR_BITS-1:0] addr);
  bus_req      = '0;
  bus_req.req  = 1'b1;
  bus_req.addr = 32'(addr);
endtask

task automatic bus_read(input logic [DBG_ADDR_BITS-1:0] addr, output logic [31:0] data);
  @(negedge clk);
  bus_read_issue(addr);
  @(negedge clk);
  bus_req = '0;
  data    = rdata;
endtask

task automatic pulse_input(input int sel);
  @(negedge clk);
  case (sel)
    PULSE_CMD:       cmd_valid       = 1'b1;
    PULSE_CLEAR_ACK: clear_resumeack = 1'b1;
    default:         ndmreset        = 1'b1;
  endcase
  @(negedge clk);
  cmd_valid       = 1'b0;
  clear_resumeack = 1'b0;
  ndmreset        = 1'b0;
endtask

function automatic logic flag_now(input int sel);
  case (sel)
    FLAG_HALTED:    return halted;
    FLAG_RESUMING:  return resuming;
    FLAG_BUSY:      return cmdbusy;
    FLAG_EXCEPTION: return cmd_exception;
    default:        return data_valid;
  endcase
endfunction

// poll on falling edges and expect the value at once for zero edges
task automatic wait_flag(input string name, input int sel, input logic val,
                         input int max_cycles);
  int n;
  n = 0;
  while (flag_now(sel) !== val && n < max_cycles) begin
    @(negedge clk);
    n++;
  end
  check_count++;
  if (flag_now(sel) !== val) begin
    err_count++;
    $display("%s did not become %0d within %0d cycles", name, val, max_cycles);
  end
endtask

// ------------------------------
// compares
// ------------------------------
task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
  end
endtask

// bits are halted, resuming, busy, go, resume
task automatic check_status(input string name, input hart_status_t got,
                            input hart_status_t exp);
  check_count++;
  if (got !== exp) begin
    err_count++;
    $display("Fail %s: got 0x%02h expected 0x%02h", name, got, exp);
  end
endtask

task automatic check_jal(input string name, input instr_word_u got, input instr_word_u exp);
  check_count++;
  if (got.jal.imm20 !== exp.jal.imm20 || got.jal.imm10_1 !== exp.jal.imm10_1 ||
      got.jal.imm11 !== exp.jal.imm11 || got.jal.imm19_12 !== exp.jal.imm19_12 ||
      got.jal.rd !== exp.jal.rd || got.jal.opcode !== exp.jal.opcode) begin
    err_count++;
    $display("Fail %s: got 0x%08h expected 0x%08h", name, got.raw, exp.raw);
  end
endtask

// jal x0 encoded as the isa scatters the immediate
function automatic instr_word_u make_jal(input int ofs);
  instr_word_u w;
  logic [20:0] imm;
  imm            = 21'(ofs);
  w.jal.imm20    = imm[20];
  w.jal.imm10_1  = imm[10:1];
  w.jal.imm11    = imm[11];
  w.jal.imm19_12 = imm[19:12];
  w.jal.rd       = 5'd0;
  w.jal.opcode   = 7'b110_1111;
  return w;
endfunction

// go and resume only show in the flags byte
task automatic expect_status(input string name, input hart_status_t exp);
  hart_status_t got;
  logic [31:0]  flags;
  bus_read(FLAGS_BASE_ADDR, flags);
  got.halted   = halted;
  got.resuming = resuming;
  got.busy     = cmdbusy;
  got.go       = flags[0];
  got.resume   = flags[1];
  check_status(name, got, exp);
  check_word("flags upper bits", {2'b00, flags[31:2]}, 32'h0);
endtask

task automatic finish_test(input string name, input int errs_before);
  test_count++;
  if (err_count == errs_before) begin
    $display("%s done, no errors", name);
  end else begin
    $display("%s done, %0d errors", name, err_count - errs_before);
  end
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic test_halt_resume();
  int errs;
  errs = err_count;
  // everything quiet out of reset
  check_word("rdata_o", rdata, 32'h0);
  check_word("data_valid_o", 32'(data_valid), 32'h0);
  check_word("cmd_exception_o", 32'(cmd_exception), 32'h0);
  check_word("debug_req_o", 32'(debug_req), 32'h0);
  for (int i = 0; i < DATA_CNT; i++) begin
    check_word($sformatf("data_o[%0d]", i), data_out[i], 32'h0);
  end
  expect_status("status after reset", 5'b00000);
  haltreq = 1'b1;
  @(negedge clk);
  check_word("debug_req_o", 32'(debug_req), 32'h1);
  haltreq = 1'b0;
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  wait_flag("halted_o", FLAG_HALTED, 1'b1, 0);
  expect_status("status after halted", 5'b10000);
  bus_write(RESUMING_ADDR, 32'h0, 4'hf);
  wait_flag("resuming_o", FLAG_RESUMING, 1'b1, 0);
  expect_status("status after resuming", 5'b01000);
  pulse_input(PULSE_CLEAR_ACK);
  expect_status("status after resume ack", 5'b00000);
  // ndmreset with halted and resuming both set
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  bus_write(RESUMING_ADDR, 32'h0, 4'hf);
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  expect_status("status before ndmreset", 5'b11000);
  pulse_input(PULSE_NDMRESET);
  expect_status("status after ndmreset", 5'b00000);
  finish_test("halt and resume flags", errs);
endtask

task automatic test_data_regs();
  int                        errs;
  logic [DATA_CNT-1:0][31:0] words;
  logic [31:0]               word;
  logic [31:0]               wdata;
  logic [31:0]               merged;
  logic [31:0]               rnd;
  logic [3:0]                be;
  logic [DBG_ADDR_BITS-1:0]  addr;
  errs = err_count;
  for (int i = 0; i < DATA_CNT; i++) begin
    words[i] = $random(seed);
  end
  @(negedge clk);
  data_in   = words;
  data_load = 1'b1;
  @(negedge clk);
  data_load = 1'b0;
  for (int i = 0; i < DATA_CNT; i++) begin
    bus_read(DATA_BASE_ADDR + DBG_ADDR_BITS'(4 * i), word);
    check_word($sformatf("loaded data %0d", i), word, words[i]);
  end
  // core byte writes on top of the loaded words
  for (int i = 0; i < DATA_CNT; i++) begin
    addr  = DATA_BASE_ADDR + DBG_ADDR_BITS'(4 * i);
    wdata = $random(seed);
    rnd   = $random(seed);
    be    = rnd[3:0];
    for (int b = 0; b < 4; b++) begin
      merged[b*8 +: 8] = be[b] ? wdata[b*8 +: 8] : words[i][b*8 +: 8];
    end
    bus_write(addr, wdata, be);
    wait_flag("data_valid_o", FLAG_DATA_VALID, 1'b1, 0);
    check_word($sformatf("data_o[%0d]", i), data_out[i], merged);
    @(negedge clk);
    check_word("data_valid_o", 32'(data_valid), 32'h0);
    bus_read(addr, word);
    check_word($sformatf("merged data %0d", i), word, merged);
    words[i] = merged;
  end
  finish_test("data registers", errs);
endtask

task automatic test_progbuf_read();
  int errs;
  errs = err_count;
  for (int i = 0; i < PB_SIZE; i++) begin
    progbuf[i] = $random(seed);
  end
  @(negedge clk);
  bus_read_issue(PB_BASE);
  // each edge returns the previous read and issues the next
  for (int i = 1; i <= PB_SIZE; i++) begin
    @(negedge clk);
    check_word($sformatf("progbuf %0d", i - 1), rdata, progbuf[i-1]);
    if (i < PB_SIZE) begin
      bus_read_issue(PB_BASE + DBG_ADDR_BITS'(4 * i));
    end else begin
      bus_req = '0;
    end
  end
  finish_test("program buffer reads", errs);
endtask

task automatic test_whereto_flags();
  int          errs;
  logic [31:0] word;
  instr_word_u jump;
  errs = err_count;
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  pulse_input(PULSE_CMD);
  bus_read(WHERETO_ADDR, word);
  jump.raw = word;
  check_jal("whereto to progbuf", jump, make_jal(int'(PB_BASE) - int'(WHERETO_ADDR)));
  expect_status("command sent", 5'b10110);
  bus_write(GOING_ADDR, 32'h0, 4'hf);
  expect_status("after going", 5'b10100);
  // core back in the park loop ends the command
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  expect_status("command done", 5'b10000);
  @(negedge clk);
  resumereq = 1'b1;
  bus_read(WHERETO_ADDR, word);
  jump.raw = word;
  check_jal("whereto to resume", jump, make_jal(int'(RESUME_ADDR) - int'(WHERETO_ADDR)));
  expect_status("resume pending", 5'b10001);
  resumereq = 1'b0;
  bus_write(RESUMING_ADDR, 32'h0, 4'hf);
  expect_status("resumed", 5'b01000);
  pulse_input(PULSE_CLEAR_ACK);
  finish_test("whereto and flags", errs);
endtask

task automatic test_cmd_end_exception();
  int errs;
  errs = err_count;
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  pulse_input(PULSE_CMD);
  wait_flag("cmdbusy_o", FLAG_BUSY, 1'b1, 0);
  bus_write(GOING_ADDR, 32'h0, 4'hf);
  bus_write(HALTED_ADDR, 32'h0, 4'hf);
  wait_flag("cmdbusy_o", FLAG_BUSY, 1'b0, WAIT_MAX);
  // second command aborted by an exception
  pulse_input(PULSE_CMD);
  wait_flag("cmdbusy_o", FLAG_BUSY, 1'b1, 0);
  bus_write(EXCEPTION_ADDR, 32'h0, 4'hf);
  wait_flag("cmd_exception_o", FLAG_EXCEPTION, 1'b1, 0);
  wait_flag("cmdbusy_o", FLAG_BUSY, 1'b0, 0);
  @(negedge clk);
  check_word("cmd_exception_o", 32'(cmd_exception), 32'h0);
  expect_status("after exception", 5'b10000);
  // a running hart takes no command
  bus_write(RESUMING_ADDR, 32'h0, 4'hf);
  pulse_input(PULSE_CMD);
  expect_status("command while running", 5'b01000);
  pulse_input(PULSE_CLEAR_ACK);
  finish_test("command end and exception", errs);
endtask

// File: tb_dbg_mem.sv
`timescale 1ns/10ps

module tb_dbg_mem
  import dbg_map_pkg::*;
  import dbg_bus_pkg::*;
();

  localparam int unsigned PB_SIZE  = 8;
  localparam int unsigned DATA_CNT = 2;
  // program buffer ends where the data words start
  localparam logic [DBG_ADDR_BITS-1:0] PB_BASE = DATA_BASE_ADDR - DBG_ADDR_BITS'(4 * PB_SIZE);
  // longest poll for a level change
  localparam int WAIT_MAX = 16;

  // selectors for the flag poll
  localparam int FLAG_HALTED     = 0;
  localparam int FLAG_RESUMING   = 1;
  localparam int FLAG_BUSY       = 2;
  localparam int FLAG_EXCEPTION  = 3;
  localparam int FLAG_DATA_VALID = 4;

  // selectors for the debugger pulses
  localparam int PULSE_CMD       = 0;
  localparam int PULSE_CLEAR_ACK = 1;
  localparam int PULSE_NDMRESET  = 2;

  logic                      clk;
  logic                      rst_n;
  bus_req_t                  bus_req;
  logic                      haltreq;
  logic                      resumereq;
  logic                      cmd_valid;
  logic                      clear_resumeack;
  logic                      ndmreset;
  logic                      data_load;
  logic [DATA_CNT-1:0][31:0] data_in;
  logic [PB_SIZE-1:0][31:0]  progbuf;
  logic [31:0]               rdata;
  logic                      debug_req;
  logic                      halted;
  logic                      resuming;
  logic                      cmdbusy;
  logic                      cmd_exception;
  logic [DATA_CNT-1:0][31:0] data_out;
  logic                      data_valid;

  integer seed;
  int     err_count;
  int     check_count;
  int     test_count;

  // ------------------------------
  // clock and DUT
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  dbg_mem_top #(
    .PROG_BUF_SIZE(PB_SIZE),
    .DATA_COUNT   (DATA_CNT)
  ) dut0 (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bus_req_i        (bus_req),
    .rdata_o          (rdata),
    .haltreq_i        (haltreq),
    .resumereq_i      (resumereq),
    .cmd_valid_i      (cmd_valid),
    .clear_resumeack_i(clear_resumeack),
    .ndmreset_i       (ndmreset),
    .data_load_i      (data_load),
    .data_i           (data_in),
    .progbuf_i        (progbuf),
    .debug_req_o      (debug_req),
    .halted_o         (halted),
    .resuming_o       (resuming),
    .cmdbusy_o        (cmdbusy),
    .cmd_exception_o  (cmd_exception),
    .data_o           (data_out),
    .data_valid_o     (data_valid)
  );

  `include "tb_dbg_mem_tasks.svh"

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    seed            = 32'h6bfe_6ad3;
    err_count       = 0;
    check_count     = 0;
    test_count      = 0;
    rst_n           = 1'b0;
    bus_req         = '0;
    haltreq         = 1'b0;
    resumereq       = 1'b0;
    cmd_valid       = 1'b0;
    clear_resumeack = 1'b0;
    ndmreset        = 1'b0;
    data_load       = 1'b0;
    data_in         = '0;
    progbuf         = '0;
    // reset held over 8 rising edges, released on a falling one
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    test_halt_resume();
    test_data_regs();
    test_progbuf_read();
    test_whereto_flags();
    test_cmd_end_exception();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
